/* auxiliary_video_information_info_frame.sv */
// ****************************************
// AVI InfoFrame generator
// Header, payload bytes and checksum from parameters
// ****************************************
`timescale 1ns/1ps
`default_nettype none

module auxiliary_video_information_info_frame
#(
    parameter hdmi_video_pkg::video_format_e VIDEO_FORMAT = hdmi_video_pkg::FMT_RGB,
    parameter logic       ACTIVE_FORMAT_INFO_PRESENT = 1'b0,   // Not valid
    parameter logic [1:0] BAR_INFO = 2'b00,                     // Bars not valid
    parameter logic [1:0] SCAN_INFO = 2'b00,                    // No data
    parameter hdmi_video_pkg::colorimetry_e COLORIMETRY = hdmi_video_pkg::COLOR_NO_DATA,
    parameter hdmi_video_pkg::aspect_ratio_e PICTURE_ASPECT_RATIO =
        hdmi_video_pkg::ASPECT_NO_DATA,
    parameter logic [3:0] ACTIVE_FORMAT_ASPECT_RATIO = hdmi_video_pkg::AFAR_SAME_AS_PICTURE,
    parameter logic       IT_CONTENT = 1'b0,                    // Set for unfiltered IT content
    parameter logic [2:0] EXTENDED_COLORIMETRY = 3'b000,
    parameter hdmi_video_pkg::quant_range_e RGB_QUANTIZATION_RANGE =
        hdmi_video_pkg::QUANT_DEFAULT,
    parameter logic [1:0] NON_UNIFORM_PICTURE_SCALING = 2'b00,  // No scaling
    parameter logic [6:0] VIDEO_ID_CODE = 7'd1,                 // CEA-861 VIC
    parameter logic [1:0] YCC_QUANTIZATION_RANGE = 2'b00,       // Limited
    parameter logic [1:0] CONTENT_TYPE = 2'b00,                 // No data
    parameter logic [3:0] PIXEL_REPETITION = 4'b0000            // None
)
(
    output hdmi_packet_pkg::packet_t avi_packet
);
    import hdmi_packet_pkg::*;
    import hdmi_video_pkg::*;

    localparam logic [4:0] LENGTH  = 5'd13;
    localparam logic [7:0] VERSION = 8'd2;

    // Extended field only meaningful with extended colorimetry
    localparam logic [2:0] EXT_COLORIMETRY =
        (COLORIMETRY == COLOR_EXTENDED) ? EXTENDED_COLORIMETRY : 3'b000;

    packet_header_u   header;
    logic [27:0][7:0] pb;                                       // PB0..PB27
    logic [7:0]       byte_sum;

    always_comb
    begin
        header.infoframe = '{spare: 3'b000, length: LENGTH, version: VERSION,
                             type_msb: PKT_AVI[7], type_code: PKT_AVI[6:0]};

        pb    = '0;                                             // Reserved bytes zero
        pb[1] = {1'b0, VIDEO_FORMAT, ACTIVE_FORMAT_INFO_PRESENT, BAR_INFO, SCAN_INFO};
        pb[2] = {COLORIMETRY, PICTURE_ASPECT_RATIO, ACTIVE_FORMAT_ASPECT_RATIO};
        pb[3] = {IT_CONTENT, EXT_COLORIMETRY, RGB_QUANTIZATION_RANGE,
                 NON_UNIFORM_PICTURE_SCALING};
        pb[4] = {1'b0, VIDEO_ID_CODE};
        pb[5] = {YCC_QUANTIZATION_RANGE, CONTENT_TYPE, PIXEL_REPETITION};

        if (BAR_INFO != 2'b00)
        begin
            pb[7:6]   = 16'hffff;                               // Top bar end
            pb[9:8]   = 16'h0000;                               // Bottom bar start
            pb[11:10] = 16'hffff;                               // Left bar end
            pb[13:12] = 16'h0000;                               // Right bar start
        end

        // Checksum covers header and PB0..PB13
        byte_sum = header.bytes.hb0 + header.bytes.hb1 + header.bytes.hb2;
        for (int i = 1; i < 14; i++)
            byte_sum = byte_sum + pb[i];
        pb[0] = 8'd0 - byte_sum;                                // Total sums to zero

        avi_packet.header = header;
        for (int s = 0; s < 4; s++)
            avi_packet.sub[s].pb = pb[s*7 +: 7];                // Seven bytes per subpacket
    end

endmodule

`default_nettype wire

/* data_island_serializer.sv */
// ****************************************
// Data island serializer
// 32 channel words per coded packet
// ****************************************
`timescale 1ns/1ps
`default_nettype none

module data_island_serializer
(
    input  wire  logic                           clk_pixel,
    input  wire  logic                           arst_n,
    input  wire  hdmi_packet_pkg::coded_packet_t coded,
    input  wire  logic                           coded_strobe,
    output hdmi_packet_pkg::island_word_t        island_word,
    output logic                                 island_valid,
    output logic                                 serializer_idle
);
    import hdmi_packet_pkg::*;

    localparam logic [4:0] LAST_WORD = 5'(ISLAND_CLOCKS - 1);

    coded_packet_t    packet_q;
    logic [4:0]       word_count;
    logic [31:0]      header_bits;                          // Header plus its ECC
    logic [3:0][63:0] sub_bits;                             // Subpackets plus ECC

    // Busy from the coded strobe through the last word
    assign serializer_idle = !(island_valid || coded_strobe);

    always_ff @(posedge clk_pixel or negedge arst_n)
    begin
        if (!arst_n)
        begin
            island_valid <= 1'b0;
            word_count   <= 5'd0;
        end
        else if (coded_strobe)
        begin
            island_valid <= 1'b1;                           // Word 0 next cycle
            word_count   <= 5'd0;
        end
        else if (island_valid)
        begin
            word_count <= word_count + 5'd1;                // Wraps to 0 after last word
            if (word_count == LAST_WORD)
                island_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk_pixel)
    begin
        if (coded_strobe)
            packet_q <= coded;
    end

    always_comb
    begin
        header_bits = {packet_q.header_ecc, packet_q.pkt.header};
        for (int j = 0; j < 4; j++)
            sub_bits[j] = {packet_q.sub_ecc[j], packet_q.pkt.sub[j]};

        island_word.ch0_header    = header_bits[word_count];
        island_word.ch0_not_first = (word_count != 5'd0);  // Low only on word 0
        for (int j = 0; j < 4; j++)
        begin
            island_word.ch1[j] = sub_bits[j][{word_count, 1'b0}];  // Even bit 2k
            island_word.ch2[j] = sub_bits[j][{word_count, 1'b1}];  // Odd bit 2k+1
        end
    end

endmodule

`default_nettype wire

/* hdmi_packet.f */
hdmi_packet_pkg.sv
hdmi_video_pkg.sv
auxiliary_video_information_info_frame.sv
packet_picker.sv
packet_bch_ecc.sv
data_island_serializer.sv
hdmi_packet_top.sv
hdmi_packet_asserts.sv
packet_checker.sv
tb_hdmi_packet.sv

/* hdmi_packet_asserts.sv */
// ****************************************
// Island framing assertions on the serializer
// ****************************************
`timescale 1ns/1ps
`default_nettype none

module hdmi_packet_asserts
(
    input  wire  logic                         clk_pixel,
    input  wire  logic                         arst_n,
    input  wire  hdmi_packet_pkg::island_word_t island_word,
    input  wire  logic                         island_valid,
    input  wire  logic                         serializer_idle
);
    int assert_errors = 0;                                  // Read by the testbench

    // High for exactly 32 cycles before each fall
    valid_length: assert property (@(posedge clk_pixel) disable iff (!arst_n)
        $fell(island_valid) |-> $past(island_valid, 32) && !$past(island_valid, 33))
    else
    begin
        assert_errors++;
        $error("island_valid not high for exactly 32 cycles");
    end

    // Low only on the first word of a packet
    first_word: assert property (@(posedge clk_pixel) disable iff (!arst_n)
        island_valid |-> (island_word.ch0_not_first == $past(island_valid)))
    else
    begin
        assert_errors++;
        $error("ch0_not_first wrong for word position");
    end

    // Idle again as soon as the last word is out, nothing queued behind it
    idle_after_packet: assert property (@(posedge clk_pixel) disable iff (!arst_n)
        $fell(island_valid) |-> serializer_idle)
    else
    begin
        assert_errors++;
        $error("serializer_idle not back high when island_valid fell");
    end

endmodule

bind data_island_serializer hdmi_packet_asserts u_asserts (.*);

`default_nettype wire

/* hdmi_packet_pkg.sv */
// ****************************************
// HDMI packet format types and constants
// ****************************************
`default_nettype none

package hdmi_packet_pkg;

    localparam int ISLAND_CLOCKS = 32;              // Pixel clocks per packet

    localparam logic [7:0] PKT_NULL = 8'h00;        // Null packet
    localparam logic [7:0] PKT_GCP  = 8'h03;        // General Control Packet
    localparam logic [7:0] PKT_AVI  = 8'h82;        // AVI InfoFrame

    typedef struct packed {
        logic [7:0] hb2;
        logic [7:0] hb1;
        logic [7:0] hb0;                            // Packet type
    } header_bytes_t;

    typedef struct packed {
        logic [2:0] spare;                          // Always zero
        logic [4:0] length;                         // Payload byte count
        logic [7:0] version;
        logic       type_msb;                       // Set for InfoFrames
        logic [6:0] type_code;
    } header_infoframe_t;

    // Same header word, seen as raw bytes or as InfoFrame fields
    typedef union packed {
        header_bytes_t     bytes;
        header_infoframe_t infoframe;
    } packet_header_u;

    typedef struct packed {
        logic [6:0][7:0] pb;                        // PB0 in low byte
    } subpacket_t;

    typedef struct packed {
        subpacket_t [3:0] sub;
        packet_header_u   header;
    } packet_t;

    typedef struct packed {
        logic [3:0][7:0] sub_ecc;                   // One BCH byte per subpacket
        logic [7:0]      header_ecc;
        packet_t         pkt;
    } coded_packet_t;

    typedef struct packed {
        logic [3:0] ch2;                            // Odd subpacket bits
        logic [3:0] ch1;                            // Even subpacket bits
        logic       ch0_not_first;                  // Channel 0 bit 3
        logic       ch0_header;                     // Channel 0 bit 2
    } island_word_t;

endpackage

`default_nettype wire

/* hdmi_packet_stimulus.txt */
// cmd[23:20] 0 strobe, 1 frame_start, 2 avmute, 3 strobe plus dropped strobe, f end
// arg[19:16] avmute level, expected type[15:8], expected key[7:0] (PB4 or SB0)
000000
100000
008210
000000
210000
000301
200000
000310
100000
210000
008210
000301
300000
f00000

/* hdmi_packet_top.sv */
// ****************************************
// HDMI data island packet path top level
// ****************************************
`timescale 1ns/1ps
`default_nettype none

module hdmi_packet_top
#(
    parameter logic [6:0] VIDEO_ID_CODE = 7'd1,
    parameter hdmi_video_pkg::video_format_e VIDEO_FORMAT = hdmi_video_pkg::FMT_RGB,
    parameter hdmi_video_pkg::aspect_ratio_e PICTURE_ASPECT_RATIO =
        hdmi_video_pkg::ASPECT_NO_DATA,
    parameter logic       IT_CONTENT = 1'b0
)
(
    input  wire  logic                   clk_pixel,
    input  wire  logic                   arst_n,
    input  wire  logic                   frame_start,
    input  wire  logic                   avmute,
    input  wire  logic                   island_strobe,
    output hdmi_packet_pkg::island_word_t island_word,
    output logic                         island_valid
);
    import hdmi_packet_pkg::*;

    packet_t       avi_packet;
    packet_t       picked;
    coded_packet_t coded;
    logic          picked_strobe;
    logic          coded_strobe;
    logic          serializer_idle;

    auxiliary_video_information_info_frame #(
        .VIDEO_FORMAT         (VIDEO_FORMAT),
        .PICTURE_ASPECT_RATIO (PICTURE_ASPECT_RATIO),
        .IT_CONTENT           (IT_CONTENT),
        .VIDEO_ID_CODE        (VIDEO_ID_CODE)
    ) u_avi (
        .avi_packet (avi_packet)
    );

    packet_picker u_picker (
        .clk_pixel       (clk_pixel),
        .arst_n          (arst_n),
        .frame_start     (frame_start),
        .avmute          (avmute),
        .island_strobe   (island_strobe),
        .serializer_idle (serializer_idle),
        .avi_packet      (avi_packet),
        .picked          (picked),
        .picked_strobe   (picked_strobe)
    );

    packet_bch_ecc u_ecc (
        .clk_pixel     (clk_pixel),
        .arst_n        (arst_n),
        .picked        (picked),
        .picked_strobe (picked_strobe),
        .coded         (coded),
        .coded_strobe  (coded_strobe)
    );

    data_island_serializer u_serializer (
        .clk_pixel       (clk_pixel),
        .arst_n          (arst_n),
        .coded           (coded),
        .coded_strobe    (coded_strobe),
        .island_word     (island_word),
        .island_valid    (island_valid),
        .serializer_idle (serializer_idle)       // Back to picker
    );

endmodule

`default_nettype wire

/* hdmi_video_pkg.sv */
// ****************************************
// AVI InfoFrame field encodings
// ****************************************
`default_nettype none

package hdmi_video_pkg;

    typedef enum logic [1:0] {
        FMT_RGB       = 2'b00,
        FMT_YCBCR422  = 2'b01,
        FMT_YCBCR444  = 2'b10,
        FMT_RESERVED  = 2'b11
    } video_format_e;

    typedef enum logic [1:0] {
        COLOR_NO_DATA  = 2'b00,
        COLOR_BT601    = 2'b01,
        COLOR_BT709    = 2'b10,
        COLOR_EXTENDED = 2'b11                      // Extended colorimetry field valid
    } colorimetry_e;

    typedef enum logic [1:0] {
        ASPECT_NO_DATA  = 2'b00,
        ASPECT_4_3      = 2'b01,
        ASPECT_16_9     = 2'b10,
        ASPECT_RESERVED = 2'b11
    } aspect_ratio_e;

    typedef enum logic [1:0] {
        QUANT_DEFAULT  = 2'b00,                     // Implied by video format
        QUANT_LIMITED  = 2'b01,
        QUANT_FULL     = 2'b10,
        QUANT_RESERVED = 2'b11
    } quant_range_e;

    localparam logic [3:0] AFAR_SAME_AS_PICTURE = 4'b1000;  // Active format default

endpackage

`default_nettype wire

/* packet_bch_ecc.sv */
// ****************************************
// BCH ECC stage for header and subpackets
// ****************************************
`timescale 1ns/1ps
`default_nettype none

module packet_bch_ecc
(
    input  wire  logic                     clk_pixel,
    input  wire  logic                     arst_n,
    input  wire  hdmi_packet_pkg::packet_t picked,
    input  wire  logic                     picked_strobe,
    output hdmi_packet_pkg::coded_packet_t coded,
    output logic                           coded_strobe
);
    import hdmi_packet_pkg::*;

    localparam logic [7:0] BCH_TAPS = 8'b1000_0011;        // 1 + x^6 + x^7 + x^8 reflected

    logic [7:0]      header_ecc;
    logic [3:0][7:0] sub_ecc;

    // Bit-serial LFSR unrolled over the block, LSB first
    function automatic logic [7:0] bch_ecc(input logic [55:0] data, input int nbits);
        logic [7:0] ecc;
        ecc = 8'd0;                                         // Fresh register per block
        for (int i = 0; i < 56; i++)
        begin
            if (i < nbits)
                ecc = (ecc >> 1) ^ ((ecc[0] ^ data[i]) ? BCH_TAPS : 8'd0);
        end
        return ecc;
    endfunction

    always_comb
    begin
        header_ecc = bch_ecc({32'd0, picked.header}, 24);   // BCH(32,24)
        for (int j = 0; j < 4; j++)
            sub_ecc[j] = bch_ecc(picked.sub[j], 56);        // BCH(64,56)
    end

    always_ff @(posedge clk_pixel or negedge arst_n)
    begin
        if (!arst_n)
            coded_strobe <= 1'b0;
        else
            coded_strobe <= picked_strobe;
    end

    always_ff @(posedge clk_pixel)
    begin
        if (picked_strobe)
        begin
            coded.pkt        <= picked;
            coded.header_ecc <= header_ecc;
            coded.sub_ecc    <= sub_ecc;
        end
    end

endmodule

`default_nettype wire

/* packet_checker.sv */
// ****************************************
// Packet checker
// Rebuilds each packet and checks type, key byte, ECC
// ****************************************
`timescale 1ns/1ps
`default_nettype none

module packet_checker
(
    input  wire  logic                         clk_pixel,
    input  wire  logic                         arst_n,
    input  wire  hdmi_packet_pkg::island_word_t island_word,
    input  wire  logic                         island_valid,
    input  wire  logic                         island_strobe,
    input  wire  logic [7:0]                   exp_type,
    input  wire  logic [7:0]                   exp_key,     // PB4, SB0 or zero
    input  wire  logic [31:0]                  step_num,
    output int                                 packet_count,
    output int                                 error_count
);
    import hdmi_packet_pkg::*;

    logic [31:0]      hdr;                                  // Header plus ECC
    logic [3:0][63:0] sub;
    int               k;
    int               latency;
    logic             timing;

    // Remainder of 1 + x^6 + x^7 + x^8, LSB first, register cleared per block
    function automatic logic [7:0] bch_remainder(input logic [55:0] d, input int n);
        logic [7:0] r;
        logic       fb;
        r = 8'd0;
        for (int i = 0; i < n; i++)
        begin
            fb = d[i] ^ r[0];
            r  = {fb, r[7:3], r[2] ^ fb, r[1] ^ fb};
        end
        return r;
    endfunction

    task automatic mismatch(input string name, input string what,
                            input logic [7:0] expv, input logic [7:0] actv, inout int errs);
        $display("Fail %s %s expected %h actual %h", name, what, expv, actv);
        errs++;
    endtask

    task automatic check_packet();
        string      name;
        int         errs;
        logic [7:0] sum;
        logic [7:0] key;
        errs = 0;
        name = $sformatf("step%0d_%s", step_num,
                         exp_type == PKT_AVI ? "avi" : exp_type == PKT_GCP ? "gcp" : "null");
        if (hdr[7:0] != exp_type)
            mismatch(name, "type", exp_type, hdr[7:0], errs);
        if (hdr[31:24] != bch_remainder({32'd0, hdr[23:0]}, 24))
            mismatch(name, "header ecc", bch_remainder({32'd0, hdr[23:0]}, 24),
                     hdr[31:24], errs);
        for (int j = 0; j < 4; j++)
            if (sub[j][63:56] != bch_remainder(sub[j][55:0], 56))
                mismatch(name, $sformatf("sub%0d ecc", j), bch_remainder(sub[j][55:0], 56),
                         sub[j][63:56], errs);
        key = (exp_type == PKT_AVI) ? sub[0][39:32] : sub[0][7:0];  // PB4 or SB0
        if (key != exp_key)
            mismatch(name, "key byte", exp_key, key, errs);
        if (exp_type == PKT_AVI)
        begin
            if (hdr[15:8] != 8'h02)
                mismatch(name, "version", 8'h02, hdr[15:8], errs);
            if (hdr[23:16] != 8'h0d)
                mismatch(name, "length", 8'h0d, hdr[23:16], errs);
            sum = hdr[7:0] + hdr[15:8] + hdr[23:16];
            for (int b = 0; b < 14; b++)
                sum = sum + sub[b / 7][(b % 7) * 8 +: 8];
            if (sum != 8'h00)
                mismatch(name, "checksum sum", 8'h00, sum, errs);
        end
        else if (hdr[23:8] != 16'd0 || sub[0][55:8] != '0 || sub[1][55:0] != '0 ||
                 sub[2][55:0] != '0 || sub[3][55:0] != '0)
        begin
            $display("Fail %s nonzero header or payload bytes outside SB0", name);
            errs++;
        end
        if (errs == 0)
            $display("%s ok", name);
        error_count += errs;
        packet_count++;
    endtask

    always @(negedge clk_pixel or negedge arst_n)
    begin
        if (!arst_n)
        begin
            k            = 0;
            timing       = 1'b0;
            latency      = 0;
            packet_count = 0;
            error_count  = 0;
        end
        else
        begin
            if (timing)
            begin
                latency++;
                if (island_valid)
                begin
                    timing = 1'b0;
                    if (latency != 3)
                    begin
                        $display("Fail step%0d latency expected 3 actual %0d", step_num, latency);
                        error_count++;
                    end
                end
                else if (latency > 40)
                begin
                    $display("No packet came out after an accepted strobe at step %0d", step_num);
                    error_count++;
                    timing = 1'b0;
                end
            end
            if (island_strobe && !island_valid && !timing)    // Accepted strobe
            begin
                timing  = 1'b1;
                latency = 0;
            end
            if (island_valid)
            begin
                hdr[k] = island_word.ch0_header;
                for (int j = 0; j < 4; j++)
                begin
                    sub[j][2 * k]     = island_word.ch1[j];
                    sub[j][2 * k + 1] = island_word.ch2[j];
                end
                k++;
                if (k == ISLAND_CLOCKS)
                begin
                    check_packet();
                    k = 0;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* packet_picker.sv */
// ****************************************
// Packet picker
// Chooses AVI, GCP or Null at each island
// ****************************************
`timescale 1ns/1ps
`default_nettype none

module packet_picker
(
    input  wire  logic                     clk_pixel,
    input  wire  logic                     arst_n,
    input  wire  logic                     frame_start,     // Pulse once per frame
    input  wire  logic                     avmute,          // Level
    input  wire  logic                     island_strobe,   // Island opportunity
    input  wire  logic                     serializer_idle,
    input  wire  hdmi_packet_pkg::packet_t avi_packet,
    output hdmi_packet_pkg::packet_t       picked,
    output logic                           picked_strobe
);
    import hdmi_packet_pkg::*;

    logic    avi_pending;
    logic    gcp_pending;
    logic    avmute_q;                                      // For change detect
    logic    accept;
    packet_t gcp_packet;
    packet_t null_packet;
    packet_t next_packet;

    // Picked packet still ahead of the ECC stage also counts as in flight
    assign accept = island_strobe && serializer_idle && !picked_strobe;

    always_comb
    begin
        gcp_packet = '0;
        gcp_packet.header.bytes.hb0 = PKT_GCP;
        gcp_packet.sub[0].pb[0] = {3'b000, ~avmute, 3'b000, avmute};  // SB0 clear/set

        null_packet = '0;
        null_packet.header.bytes.hb0 = PKT_NULL;

        if (avi_pending)                                    // AVI has priority
            next_packet = avi_packet;
        else if (gcp_pending)
            next_packet = gcp_packet;
        else
            next_packet = null_packet;
    end

    always_ff @(posedge clk_pixel or negedge arst_n)
    begin
        if (!arst_n)
        begin
            avi_pending   <= 1'b0;
            gcp_pending   <= 1'b0;
            avmute_q      <= 1'b0;
            picked_strobe <= 1'b0;
        end
        else
        begin
            picked_strobe <= accept;
            avmute_q      <= avmute;

            if (frame_start)                                // New request wins over clear
                avi_pending <= 1'b1;
            else if (accept && avi_pending)
                avi_pending <= 1'b0;

            if (avmute != avmute_q)                         // Any AVMUTE edge
                gcp_pending <= 1'b1;
            else if (accept && !avi_pending && gcp_pending)
                gcp_pending <= 1'b0;
        end
    end

    always_ff @(posedge clk_pixel)
    begin
        if (accept)
            picked <= next_packet;                          // Payload only
    end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build and run the HDMI packet testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_hdmi_packet -f hdmi_packet.f -o sim_hdmi_packet
if [ $? -ne 0 ]; then
    echo "Compile step failed"
    exit 1
fi

./obj_dir/sim_hdmi_packet > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qF '** FAIL **' sim.log; then
    exit 1
fi
exit 0

/* tb_hdmi_packet.sv */
// ****************************************
// Testbench for the HDMI packet path
// ****************************************
`timescale 1ns/1ps
`default_nettype none

module tb_hdmi_packet;
    import hdmi_packet_pkg::*;

    localparam int STIM_DEPTH = 64;                         // Stimulus lines held

    logic         clk_pixel;
    logic         arst_n;
    logic         frame_start;
    logic         avmute;
    logic         island_strobe;
    island_word_t island_word;
    logic         island_valid;
    logic [7:0]   exp_type;
    logic [7:0]   exp_key;
    int           step_num;
    int           packet_count;
    int           error_count;                              // From the checker
    int           tb_errors;
    int           total_errors;
    int           accepted;
    logic         timed_out;
    logic [31:0]  lfsr;
    logic [23:0]  stim [0:STIM_DEPTH-1];                    // cmd, arg, type, key

    hdmi_packet_top #(
        .VIDEO_ID_CODE        (7'd16),
        .VIDEO_FORMAT         (hdmi_video_pkg::FMT_RGB),
        .PICTURE_ASPECT_RATIO (hdmi_video_pkg::ASPECT_16_9)
    ) DUT (
        .clk_pixel     (clk_pixel),
        .arst_n        (arst_n),
        .frame_start   (frame_start),
        .avmute        (avmute),
        .island_strobe (island_strobe),
        .island_word   (island_word),
        .island_valid  (island_valid)
    );

    packet_checker u_checker (.*);

    initial
    begin
        clk_pixel = 1'b0;
        forever #4 clk_pixel = ~clk_pixel;                  // 8 ns period
    end

    // Fibonacci taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic idle_gap();
        int gap;
        gap = 1;
        for (int b = 0; b < 3; b++)
        begin
            lfsr = lfsr_next(lfsr);                         // One step per bit
            gap  = gap + (int'(lfsr[0]) << b);
        end
        repeat (gap) @(posedge clk_pixel);
    endtask

    task automatic wait_valid(input logic level);
        int n;
        n = 0;
        while (island_valid !== level && n < 50)
        begin
            @(negedge clk_pixel);
            n++;
        end
        if (island_valid !== level)
        begin
            $display("Timed out waiting for island_valid to become %0b", level);
            timed_out = 1'b1;
        end
    endtask

    task automatic send_strobe(input logic [7:0] t, input logic [7:0] key, input logic extra);
        @(posedge clk_pixel);
        island_strobe <= 1'b1;
        exp_type      <= t;
        exp_key       <= key;
        @(negedge clk_pixel);
        if (!island_valid)                                  // Idle while strobe is sampled
            accepted++;
        @(posedge clk_pixel);
        island_strobe <= 1'b0;
        wait_valid(1'b1);
        if (extra && !timed_out)
        begin
            @(posedge clk_pixel);
            island_strobe <= 1'b1;                          // Mid-stream, must be dropped
            @(negedge clk_pixel);
            if (!island_valid)
                accepted++;
            @(posedge clk_pixel);
            island_strobe <= 1'b0;
        end
        if (!timed_out)
            wait_valid(1'b0);
    endtask

    initial
    begin
        arst_n        = 1'b0;
        frame_start   = 1'b0;
        avmute        = 1'b0;
        island_strobe = 1'b0;
        exp_type      = 8'h00;
        exp_key       = 8'h00;
        step_num      = 0;
        accepted      = 0;
        tb_errors     = 0;
        total_errors  = 0;
        timed_out     = 1'b0;
        lfsr          = 32'h99e7_dd46;
        $readmemh("hdmi_packet_stimulus.txt", stim);
        repeat (8) @(posedge clk_pixel);
        arst_n <= 1'b1;

        while (step_num < STIM_DEPTH && stim[step_num][23:20] != 4'hf && !timed_out)
        begin
            idle_gap();
            case (stim[step_num][23:20])
                4'h1:
                begin
                    frame_start <= 1'b1;
                    @(posedge clk_pixel);
                    frame_start <= 1'b0;
                end
                4'h2: avmute <= stim[step_num][16];
                4'h3: send_strobe(stim[step_num][15:8], stim[step_num][7:0], 1'b1);
                default: send_strobe(stim[step_num][15:8], stim[step_num][7:0], 1'b0);
            endcase
            step_num++;
        end
        repeat (4) @(posedge clk_pixel);

        if (!timed_out && (step_num >= STIM_DEPTH || stim[step_num][23:20] !== 4'hf))
        begin
            $display("Stimulus stopped at step %0d without reaching its end marker", step_num);
            tb_errors++;
        end
        if (packet_count != accepted)
        begin
            $display("Packet count %0d does not match %0d accepted strobes",
                     packet_count, accepted);
            tb_errors++;
        end
        total_errors = error_count + tb_errors + DUT.u_serializer.u_asserts.assert_errors;
        $display("steps %0d, packets %0d, errors %0d", step_num, packet_count, total_errors);
        if (total_errors == 0 && !timed_out)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire
